/* hw/boardPkg.sv */
package boardPkg;

    // board geometry with walls in columns 0 and 9
    localparam int BOARD_WIDTH = 10;
    localparam int BOARD_HEIGHT = 12;

    // shape table layout
    localparam int SHAPE_SIZE = 4;
    localparam int ROTATIONS = 4;
    localparam int SPAWN_COL = 3;

    // cycles between gravity steps
    localparam int DROP_PERIOD = 64;

    // valid piece codes
    localparam int FIRST_PIECE = 1;
    localparam int LAST_PIECE = 7;
    localparam int SQUARE_PIECE = 2;
    localparam int LINE_PIECE = 7;

    // bit 0 is the leftmost column, row 0 the top row
    typedef logic [BOARD_WIDTH-1:0] rowT;
    typedef rowT [BOARD_HEIGHT-1:0] boardT;
    typedef logic [BOARD_HEIGHT-1:0] rowMaskT;
    typedef logic [$clog2(BOARD_HEIGHT)-1:0] rowIdxT;

    // nibble n is shape row n, nibble msb lands on SPAWN_COL
    typedef logic [SHAPE_SIZE*SHAPE_SIZE-1:0] shapeT;
    typedef shapeT [ROTATIONS-1:0] shapeSetT;
    typedef logic [3:0] pieceCodeT;
    typedef logic [1:0] rotT;

    localparam rowT WALL_ROW = {1'b1, {(BOARD_WIDTH-2){1'b0}}, 1'b1};

endpackage

/* hw/controlPkg.sv */
package controlPkg;

    // drop controller states
    typedef enum logic [2:0] {
        READY,
        FETCH,
        SPAWN,
        FALLING,
        STORING,
        CLEARING
    } dropStateT;

    // button front end
    localparam int SYNC_STAGES = 2;
    localparam int BUTTON_COUNT = 4;

    // gravity counter has to hold DROP_PERIOD itself
    localparam int DROP_CNT_WIDTH = $clog2(boardPkg::DROP_PERIOD + 1);

endpackage

/* hw/inputEdges.sv */
module inputEdges
    import controlPkg::*;
(
    input  logic gameclk,
    input  logic rst,
    input  logic newPiece,
    input  logic moveLeft,
    input  logic moveRight,
    input  logic rotateButton,
    output logic newPieceEdge,
    output logic leftEdge,
    output logic rightEdge,
    output logic rotateEdge
);

    logic [BUTTON_COUNT-1:0] buttons;
    logic [BUTTON_COUNT-1:0] edges;
    // sync stages plus one older sample for edge detect
    logic [SYNC_STAGES:0] history [BUTTON_COUNT];

    assign buttons = {rotateButton, moveRight, moveLeft, newPiece};

    always_ff @(posedge gameclk) begin
        if (rst) begin
            for (int b = 0; b < BUTTON_COUNT; b++) begin
                history[b] <= '0;
            end
            edges <= '0;
        end else begin
            for (int b = 0; b < BUTTON_COUNT; b++) begin
                history[b] <= {history[b][SYNC_STAGES-1:0], buttons[b]};
                // rising edge seen on the synchronized sample
                edges[b] <= history[b][SYNC_STAGES-1] & ~history[b][SYNC_STAGES];
            end
        end
    end

    assign newPieceEdge = edges[0];
    assign leftEdge = edges[1];
    assign rightEdge = edges[2];
    assign rotateEdge = edges[3];

endmodule

/* hw/pieceRom.sv */
module pieceRom
    import boardPkg::*;
(
    input  logic      gameclk,
    input  logic      fetch,
    input  pieceCodeT pieceCode,
    output shapeSetT  shapes
);

    // one line per code, rotation 0 in the low 16 bits
    shapeSetT shapeTable [FIRST_PIECE:LAST_PIECE];

    initial begin
        $readmemh("hw/pieces.mem", shapeTable);
    end

    always_ff @(posedge gameclk) begin
        if (fetch) begin
            if (pieceCode >= FIRST_PIECE && pieceCode <= LAST_PIECE) begin
                shapes <= shapeTable[pieceCode];
            end else begin
                // unknown code gives an empty piece
                shapes <= '0;
            end
        end
    end

endmodule

/* hw/pieceField.sv */
module pieceField
    import boardPkg::*;
(
    input  logic     gameclk,
    input  logic     rst,
    input  logic     spawn,
    input  logic     shiftLeft,
    input  logic     shiftRight,
    input  logic     rotate,
    input  logic     stepDown,
    input  logic     clearPiece,
    input  shapeSetT shapes,
    output boardT    currentPlane,
    output boardT    nextPlane
);

    // one plane per rotation, all moved in lockstep
    boardT planes [ROTATIONS];
    rotT   rot;
    rotT   nextRot;

    // place a 4x4 shape in the top rows at the spawn column
    function automatic boardT spawnPlane(shapeT shape);
        boardT plane;
        plane = '0;
        for (int r = 0; r < SHAPE_SIZE; r++) begin
            for (int k = 0; k < SHAPE_SIZE; k++) begin
                plane[r][SPAWN_COL + k] = shape[SHAPE_SIZE*r + SHAPE_SIZE - 1 - k];
            end
        end
        return plane;
    endfunction

    always_ff @(posedge gameclk) begin
        if (rst || clearPiece) begin
            for (int p = 0; p < ROTATIONS; p++) begin
                planes[p] <= '0;
            end
            rot <= '0;
        end else if (spawn) begin
            for (int p = 0; p < ROTATIONS; p++) begin
                planes[p] <= spawnPlane(shapes[p]);
            end
            rot <= '0;
        end else if (stepDown) begin
            // row i takes row i-1, empty row enters at the top
            for (int p = 0; p < ROTATIONS; p++) begin
                planes[p] <= planes[p] << BOARD_WIDTH;
            end
        end else if (shiftLeft) begin
            for (int p = 0; p < ROTATIONS; p++) begin
                for (int i = 0; i < BOARD_HEIGHT; i++) begin
                    planes[p][i] <= planes[p][i] >> 1;
                end
            end
        end else if (shiftRight) begin
            for (int p = 0; p < ROTATIONS; p++) begin
                for (int i = 0; i < BOARD_HEIGHT; i++) begin
                    planes[p][i] <= planes[p][i] << 1;
                end
            end
        end else if (rotate) begin
            rot <= nextRot;
        end
    end

    // rotation wraps from 3 back to 0
    assign nextRot = rot + 1'b1;

    assign currentPlane = planes[rot];
    assign nextPlane = planes[nextRot];

endmodule

/* hw/stackBoard.sv */
module stackBoard
    import boardPkg::*;
(
    input  logic    gameclk,
    input  logic    rst,
    input  logic    store,
    input  logic    clearStep,
    input  boardT   currentPlane,
    input  rowMaskT fullRows,
    output boardT   stackRows,
    output boardT   boardRows
);

    boardT  stack;
    rowIdxT lowestFull;

    // highest index wins, that is the lowest row on screen
    always_comb begin
        lowestFull = '0;
        for (int i = 0; i < BOARD_HEIGHT; i++) begin
            if (fullRows[i]) begin
                lowestFull = rowIdxT'(i);
            end
        end
    end

    always_ff @(posedge gameclk) begin
        if (rst) begin
            for (int i = 0; i < BOARD_HEIGHT; i++) begin
                stack[i] <= WALL_ROW;
            end
        end else if (store) begin
            stack <= stack | currentPlane;
        end else if (clearStep) begin
            // rows above the cleared one drop by one
            for (int i = 1; i < BOARD_HEIGHT; i++) begin
                if (i <= lowestFull) begin
                    stack[i] <= stack[i-1];
                end
            end
            stack[0] <= WALL_ROW;
        end
    end

    assign stackRows = stack;

    // what the player sees
    assign boardRows = stack | currentPlane;

endmodule

/* hw/collisionCheck.sv */
module collisionCheck
    import boardPkg::*;
(
    input  boardT   currentPlane,
    input  boardT   nextPlane,
    input  boardT   stackRows,
    output logic    canLeft,
    output logic    canRight,
    output logic    canRotate,
    output logic    landed,
    output rowMaskT fullRows
);

    logic leftHit;
    logic rightHit;
    logic rotateHit;
    logic restHit;

    always_comb begin
        leftHit = 1'b0;
        rightHit = 1'b0;
        rotateHit = 1'b0;
        restHit = 1'b0;
        for (int i = 0; i < BOARD_HEIGHT; i++) begin
            // walls are in the stack, so they block like settled cells
            leftHit = leftHit | (|((currentPlane[i] >> 1) & stackRows[i]));
            rightHit = rightHit | (|((currentPlane[i] << 1) & stackRows[i]));
            rotateHit = rotateHit | (|(nextPlane[i] & stackRows[i]));
            fullRows[i] = &stackRows[i];
        end
        // piece resting on the stack row underneath
        for (int i = 0; i < BOARD_HEIGHT - 1; i++) begin
            restHit = restHit | (|(currentPlane[i] & stackRows[i+1]));
        end
    end

    assign canLeft = ~leftHit;
    assign canRight = ~rightHit;
    assign canRotate = ~rotateHit;
    assign landed = (|currentPlane[BOARD_HEIGHT-1]) | restHit;

endmodule

/* hw/dropControl.sv */
module dropControl
    import boardPkg::*;
    import controlPkg::*;
(
    input  logic    gameclk,
    input  logic    rst,
    input  logic    newPieceEdge,
    input  logic    leftEdge,
    input  logic    rightEdge,
    input  logic    rotateEdge,
    input  logic    canLeft,
    input  logic    canRight,
    input  logic    canRotate,
    input  logic    landed,
    input  rowMaskT fullRows,
    output logic    fetch,
    output logic    spawn,
    output logic    shiftLeft,
    output logic    shiftRight,
    output logic    rotate,
    output logic    stepDown,
    output logic    clearPiece,
    output logic    store,
    output logic    clearStep,
    output logic    pieceActive
);

    dropStateT state;
    dropStateT nextState;
    logic [DROP_CNT_WIDTH-1:0] gravityCount;
    logic gravityDue;

    assign gravityDue = (state == FALLING) && (gravityCount == DROP_CNT_WIDTH'(DROP_PERIOD));

    assign fetch = (state == FETCH);
    assign spawn = (state == SPAWN);
    assign store = (state == STORING);
    assign clearPiece = (state == STORING);
    assign clearStep = (state == CLEARING) && (|fullRows);
    assign pieceActive = (state != READY);
    assign stepDown = gravityDue && !landed;

    // gravity wins, otherwise one legal move per cycle
    always_comb begin
        shiftLeft = 1'b0;
        shiftRight = 1'b0;
        rotate = 1'b0;
        if (state == FALLING && !gravityDue) begin
            if (leftEdge && canLeft) begin
                shiftLeft = 1'b1;
            end else if (rightEdge && canRight) begin
                shiftRight = 1'b1;
            end else if (rotateEdge && canRotate) begin
                rotate = 1'b1;
            end
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            READY:    nextState = newPieceEdge ? FETCH : READY;
            FETCH:    nextState = SPAWN;
            SPAWN:    nextState = FALLING;
            FALLING:  nextState = (gravityDue && landed) ? STORING : FALLING;
            STORING:  nextState = CLEARING;
            // one full row removed per cycle
            CLEARING: nextState = (|fullRows) ? CLEARING : READY;
            default:  nextState = READY;
        endcase
    end

    always_ff @(posedge gameclk) begin
        if (rst) begin
            state <= READY;
            gravityCount <= '0;
        end else begin
            state <= nextState;
            if (state == SPAWN) begin
                gravityCount <= '0;
            end else if (gravityDue) begin
                // restart at one so steps stay DROP_PERIOD apart
                gravityCount <= DROP_CNT_WIDTH'(1);
            end else if (state == FALLING) begin
                gravityCount <= gravityCount + 1'b1;
            end
        end
    end

endmodule

/* hw/gameController.sv */
module gameController
    import boardPkg::*;
(
    input  logic      gameclk,
    input  logic      rst,
    input  logic      newPiece,
    input  logic      moveLeft,
    input  logic      moveRight,
    input  logic      rotateButton,
    input  pieceCodeT pieceCode,
    output boardT     boardRows,
    output logic      pieceActive
);

    // button pulses
    logic newPieceEdge;
    logic leftEdge;
    logic rightEdge;
    logic rotateEdge;

    // controller commands
    logic fetch;
    logic spawn;
    logic shiftLeft;
    logic shiftRight;
    logic rotate;
    logic stepDown;
    logic clearPiece;
    logic store;
    logic clearStep;

    // piece and stack data
    shapeSetT shapes;
    boardT    currentPlane;
    boardT    nextPlane;
    boardT    stackRows;
    rowMaskT  fullRows;
    logic     canLeft;
    logic     canRight;
    logic     canRotate;
    logic     landed;

    inputEdges i_inputEdges (
        .gameclk, .rst, .newPiece, .moveLeft, .moveRight, .rotateButton,
        .newPieceEdge, .leftEdge, .rightEdge, .rotateEdge
    );

    pieceRom i_pieceRom (
        .gameclk, .fetch, .pieceCode, .shapes
    );

    pieceField i_pieceField (
        .gameclk, .rst, .spawn, .shiftLeft, .shiftRight, .rotate, .stepDown,
        .clearPiece, .shapes, .currentPlane, .nextPlane
    );

    stackBoard i_stackBoard (
        .gameclk, .rst, .store, .clearStep, .currentPlane, .fullRows,
        .stackRows, .boardRows
    );

    collisionCheck i_collisionCheck (
        .currentPlane, .nextPlane, .stackRows,
        .canLeft, .canRight, .canRotate, .landed, .fullRows
    );

    dropControl i_dropControl (
        .gameclk, .rst, .newPieceEdge, .leftEdge, .rightEdge, .rotateEdge,
        .canLeft, .canRight, .canRotate, .landed, .fullRows,
        .fetch, .spawn, .shiftLeft, .shiftRight, .rotate, .stepDown,
        .clearPiece, .store, .clearStep, .pieceActive
    );

endmodule

/* dv/gameControllerTb.sv */
module gameControllerTb
    import boardPkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ENTRY_COUNT = 8;
    localparam int RESET_CYCLES = 2;
    localparam int PRESS_HIGH = 3;
    localparam int PRESS_LOW = 6;
    localparam int MAX_GAP = 8;
    localparam int CYCLE_LIMIT = ENTRY_COUNT * (BOARD_HEIGHT + 2) * DROP_PERIOD + 1000;
    localparam logic [31:0] SEED = 32'h7fd5_424e;

    // piece codes used in the table
    localparam pieceCodeT SQUARE_CODE = pieceCodeT'(SQUARE_PIECE);
    localparam pieceCodeT LINE_CODE = pieceCodeT'(LINE_PIECE);

    // button selectors for pressButton
    localparam int ROTATE_BTN = 0;
    localparam int LEFT_BTN = 1;
    localparam int RIGHT_BTN = 2;

    logic      gameclk = 1'b0;
    logic      rst;
    logic      newPiece;
    logic      moveLeft;
    logic      moveRight;
    logic      rotateButton;
    pieceCodeT pieceCode;
    boardT     boardRows;
    logic      pieceActive;

    // stimulus table with one row per piece dropped
    pieceCodeT codeTab [ENTRY_COUNT];
    int        rotTab [ENTRY_COUNT];
    int        leftTab [ENTRY_COUNT];
    int        rightTab [ENTRY_COUNT];
    boardT     expTab [ENTRY_COUNT];
    int        entryFill;
    int        cycleCount;

    gameController i_dut (
        .gameclk, .rst, .newPiece, .moveLeft, .moveRight, .rotateButton,
        .pieceCode, .boardRows, .pieceActive
    );

    always #50 gameclk = ~gameclk;

    always @(posedge gameclk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            failRun();
        end
    end

    task automatic failRun();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic checkBoard(input string name, input boardT actual, input boardT expected);
        if (actual !== expected) begin
            $display("ERROR %s: got 0x%h expected 0x%h", name, actual, expected);
            failRun();
        end
    endtask

    task automatic checkBit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("ERROR %s: got 0x%h expected 0x%h", name, actual, expected);
            failRun();
        end
    endtask

    // empty playfield with only the side walls set
    function automatic boardT wallBoard();
        boardT b;
        for (int i = 0; i < BOARD_HEIGHT; i++) begin
            b[i] = 10'h201;
        end
        return b;
    endfunction

    // rotation 0 cells of the pieces used here
    function automatic boardT spawnShape(input pieceCodeT code);
        boardT b;
        b = '0;
        if (code == SQUARE_CODE) begin
            b[0] = 10'h030;
            b[1] = 10'h030;
        end else if (code == LINE_CODE) begin
            b[0] = 10'h078;
        end
        return b;
    endfunction

    task automatic addEntry(input pieceCodeT code, input int rots, input int lefts,
                            input int rights, input boardT expected);
        codeTab[entryFill] = code;
        rotTab[entryFill] = rots;
        leftTab[entryFill] = lefts;
        rightTab[entryFill] = rights;
        expTab[entryFill] = expected;
        entryFill++;
    endtask

    task automatic loadTable();
        boardT b;
        entryFill = 0;
        // squares at columns 1-2, 3-4 and 5-6 on the floor
        b = wallBoard();
        b[10] = 10'h207;
        b[11] = 10'h207;
        addEntry(SQUARE_CODE, 0, 8, 0, b);
        b[10] = 10'h21F;
        b[11] = 10'h21F;
        addEntry(SQUARE_CODE, 0, 1, 0, b);
        b[10] = 10'h27F;
        b[11] = 10'h27F;
        addEntry(SQUARE_CODE, 0, 0, 1, b);
        // vertical line in column 1 resting on the first square
        for (int r = 6; r < 10; r++) begin
            b[r] = 10'h203;
        end
        addEntry(LINE_CODE, 1, 4, 0, b);
        // last square fills rows 10 and 11, line drops by two rows
        b = wallBoard();
        for (int r = 8; r < 12; r++) begin
            b[r] = 10'h203;
        end
        addEntry(SQUARE_CODE, 0, 0, 3, b);
        b[10] = 10'h233;
        b[11] = 10'h233;
        addEntry(SQUARE_CODE, 0, 0, 0, b);
        // vertical line in column 5 on top of that square
        b[6] = 10'h221;
        b[7] = 10'h221;
        b[8] = 10'h223;
        b[9] = 10'h223;
        addEntry(LINE_CODE, 1, 0, 0, b);
        b[4] = 10'h261;
        b[5] = 10'h261;
        addEntry(SQUARE_CODE, 0, 0, 1, b);
    endtask

    task automatic driveButton(input int button, input logic level);
        case (button)
            ROTATE_BTN: rotateButton <= level;
            LEFT_BTN:   moveLeft <= level;
            default:    moveRight <= level;
        endcase
    endtask

    task automatic pressButton(input int button);
        @(posedge gameclk);
        driveButton(button, 1'b1);
        repeat (PRESS_HIGH) @(posedge gameclk);
        driveButton(button, 1'b0);
        // next press starts on the following edge
        repeat (PRESS_LOW - 1) @(posedge gameclk);
    endtask

    // ends on the first falling clock edge with pieceActive high
    task automatic startPiece(input pieceCodeT code);
        int held;
        held = 0;
        @(posedge gameclk);
        pieceCode <= code;
        newPiece <= 1'b1;
        @(negedge gameclk);
        while (!pieceActive) begin
            @(posedge gameclk);
            held++;
            if (held == PRESS_HIGH) begin
                newPiece <= 1'b0;
            end
            @(negedge gameclk);
        end
    endtask

    initial begin
        boardT settled;
        int gap;
        rst = 1'b1;
        newPiece = 1'b0;
        moveLeft = 1'b0;
        moveRight = 1'b0;
        rotateButton = 1'b0;
        pieceCode = '0;
        void'($urandom(SEED));
        loadTable();

        repeat (RESET_CYCLES) @(posedge gameclk);
        rst <= 1'b0;
        @(negedge gameclk);
        checkBit("pieceActive", pieceActive, 1'b0);
        checkBoard("boardRows", boardRows, wallBoard());
        settled = wallBoard();

        for (int e = 0; e < ENTRY_COUNT; e++) begin
            gap = $urandom % MAX_GAP;
            repeat (gap) @(posedge gameclk);
            startPiece(codeTab[e]);
            // planes are loaded two cycles after pieceActive rises
            repeat (2) @(negedge gameclk);
            checkBoard("boardRows", boardRows, settled | spawnShape(codeTab[e]));
            repeat (rotTab[e]) pressButton(ROTATE_BTN);
            repeat (leftTab[e]) pressButton(LEFT_BTN);
            repeat (rightTab[e]) pressButton(RIGHT_BTN);
            @(negedge gameclk);
            while (pieceActive) begin
                @(negedge gameclk);
            end
            checkBoard("boardRows", boardRows, expTab[e]);
            settled = expTab[e];
        end

        $display("Everything OK");
        $finish;
    end

endmodule

/* hw/pieces.mem */
// one line per piece code from 1, four 16-bit shapes: rotation 3 left ... rotation 0 right
046400E404C4004E
0066006600660066
026400C6026400C6
0462006C0462006C
064400E2044C008E
044600E80C44002E
2222000F2222000F

/* src.f */
hw/boardPkg.sv
hw/controlPkg.sv
hw/inputEdges.sv
hw/pieceRom.sv
hw/pieceField.sv
hw/stackBoard.sv
hw/collisionCheck.sv
hw/dropControl.sv
hw/gameController.sv
dv/gameControllerTb.sv
